// ==== width_gearbox.f ====
logic/gearbox_pkg.sv
logic/gearbox_in_stage.sv
logic/gearbox_core.sv
logic/gearbox_out_stage.sv
logic/width_gearbox.sv
verification/tb_width_gearbox.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the width_gearbox testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_width_gearbox \
    -f width_gearbox.f \
    -o tb_width_gearbox > build.log 2>&1 \
    && ./obj_dir/tb_width_gearbox > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1

// ==== verification/tb_width_gearbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_width_gearbox;
    import gearbox_pkg::*;

    localparam logic [31:0] SEED = 32'd73860;
    localparam int MAX_BEATS   = 6;   // Beats per random packet, upper bound
    localparam int N_PKTS      = 64;  // Packets over all tests
    localparam int EXTRA_BEATS = 2;   // Beats lost to the clear
    localparam int LIMIT       = 20 * (MAX_BEATS * N_PKTS + EXTRA_BEATS) + 200;

    logic        CLK       = 1'b0;
    logic        RST_N     = 1'b1;   // Dropped at time zero for a clean edge
    logic        clear     = 1'b0;
    out_cnt_t    out_bw    = out_cnt_t'(OUT_W);
    logic        in_valid  = 1'b0;
    in_beat_t    in_beat   = '0;
    logic        out_ready = 1'b1;
    logic        in_ready;
    logic        out_valid;
    out_word_t   out_word;

    logic        bp_en      = 1'b0;  // Random out_ready gaps on
    logic [31:0] data_seed  = SEED;
    logic [31:0] ready_seed = SEED + 32'd1;
    bit          bitq[$];            // Reference bitstream, oldest first
    bit          endq[$];            // Marks a packet's final bit
    out_word_t   exp_word   = '0;    // Next word the DUT owes
    int          n_taken    = 0;     // Beats accepted so far
    int          cycles     = 0;
    int          errors     = 0;
    int          err_mark   = 0;
    int          n_pass     = 0;
    int          n_fail     = 0;

    width_gearbox u_dut (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .clear     (clear),
        .out_bw    (out_bw),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready)
    );

    always #50 CLK = ~CLK;               // 100 ns period

    // 32-bit LCG, upper bits are the useful ones
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Cut the next word off the head of the bitstream
    function automatic out_word_t head_word();
        out_word_t w;
        int        k;
        w = '0;
        k = 0;
        while (k < int'(out_bw) && k < bitq.size() && !w.last) begin
            w.data[k] = bitq[k];
            w.last    = endq[k];         // Stop at packet end
            k++;
        end
        w.nbits = out_cnt_t'(k);
        return w;
    endfunction

    // ==============================
    // Reference model
    // ==============================
    always @(posedge CLK) begin
        if (!RST_N || clear) begin
            bitq.delete();               // Everything in flight is dropped
            endq.delete();
        end else begin
            if (out_valid && out_ready) begin
                for (int i = 0; i < int'(exp_word.nbits) && bitq.size() != 0; i++) begin
                    void'(bitq.pop_front());
                    void'(endq.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                for (int i = 0; i < int'(in_beat.nbits); i++) begin
                    bitq.push_back(in_beat.data[i]);
                    endq.push_back(in_beat.last && (i == int'(in_beat.nbits) - 1));
                end
                n_taken++;
            end
        end
        exp_word <= head_word();         // Seen by checks on the next edge
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Run stopped after %0d cycles with tests still pending", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(posedge CLK) begin
        #1;
        ready_seed = lcg_next(ready_seed);
        out_ready  = bp_en ? (ready_seed[31:30] != 2'b00) : 1'b1; // About one stall in four
    end

    // ==============================
    // Checks
    // ==============================
    a_word_match : assert property (@(posedge CLK) disable iff (!RST_N || clear)
        out_valid && out_ready |-> out_word == exp_word)
    else begin
        errors++;
        $display("MISMATCH out_word: expected %h, got %h",
                 $sampled(exp_word), $sampled(out_word));
    end

    a_word_hold : assert property (@(posedge CLK) disable iff (!RST_N || clear)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
    else begin
        errors++;
        $display("out_word moved or vanished while out_ready was low");
    end

    a_reset_quiet : assert property (@(posedge CLK) !RST_N |-> !out_valid)
    else begin
        errors++;
        $display("out_valid was high during reset");
    end

    a_ready_up : assert property (@(posedge CLK) $rose(RST_N) |=> in_ready && !out_valid)
    else begin
        errors++;
        $display("in_ready not high, or out_valid high, one cycle after reset");
    end

    a_clear_quiet : assert property (@(posedge CLK) disable iff (!RST_N) clear |=> !out_valid)
    else begin
        errors++;
        $display("out_valid still high on the cycle after clear");
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic send_beat(input int nb, input logic lst);
        int prev;
        prev          = n_taken;
        data_seed     = lcg_next(data_seed);
        in_valid      = 1'b1;
        in_beat.data  = data_seed[31:16]; // Junk above nbits too
        in_beat.nbits = in_cnt_t'(nb);
        in_beat.last  = lst;
        do begin
            @(posedge CLK);
            #1;
        end while (n_taken == prev);     // Model saw the transfer
        in_valid = 1'b0;
    endtask

    // Zero nb_fixed picks each width at random
    task automatic send_packet(input int nbeats, input int nb_fixed);
        int nb;
        for (int i = 0; i < nbeats; i++) begin
            data_seed = lcg_next(data_seed);
            nb        = (nb_fixed != 0) ? nb_fixed : 1 + int'(data_seed[31:28]);
            send_beat(nb, i == nbeats - 1);
        end
    endtask

    task automatic random_packets(input int count);
        for (int p = 0; p < count; p++) begin
            data_seed = lcg_next(data_seed);
            send_packet(1 + int'(data_seed[27:24]) % MAX_BEATS, 0);
        end
    endtask

    task automatic wait_drain();
        while (bitq.size() != 0) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        RST_N = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        RST_N = 1'b1;
        repeat (3) @(posedge CLK);
        #1;
        end_test("reset");

        random_packets(8);               // Full 32-bit words
        wait_drain();
        end_test("packing");

        send_packet(4, 16);              // 64 bits, no remainder
        send_packet(3, 0);
        send_packet(2, 5);               // 10-bit tail
        wait_drain();
        end_test("tail_flush");

        bp_en = 1'b1;
        random_packets(40);
        wait_drain();
        end_test("back_pressure");

        out_bw = out_cnt_t'(7);          // Core is empty here
        random_packets(4);
        wait_drain();
        out_bw = out_cnt_t'(16);
        random_packets(4);
        wait_drain();
        bp_en  = 1'b0;
        out_bw = out_cnt_t'(1);
        random_packets(4);
        wait_drain();
        end_test("width_change");

        out_bw = out_cnt_t'(4);          // Narrow words keep out_valid busy
        send_beat(9, 1'b0);
        send_beat(12, 1'b0);             // Packet left open
        while (!out_valid) begin         // Clear lands on a live word
            @(posedge CLK);
            #1;
        end
        clear = 1'b1;
        @(posedge CLK);
        #1;
        clear = 1'b0;
        random_packets(1);
        wait_drain();
        end_test("clear");

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/width_gearbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module width_gearbox (
    input  wire                     CLK,
    input  wire                     RST_N,
    input  wire                     clear,
    input  wire gearbox_pkg::out_cnt_t  out_bw,
    input  wire                     in_valid,
    input  wire gearbox_pkg::in_beat_t  in_beat,
    output logic                    in_ready,
    output logic                    out_valid,
    output gearbox_pkg::out_word_t  out_word,
    input  wire                     out_ready
);
    import gearbox_pkg::*;

    // ==============================
    // Stage links
    // ==============================
    logic      beat_valid;  // Skid buffer to core
    logic      beat_ready;
    in_beat_t  beat;
    logic      word_valid;  // Core to output slice
    logic      word_ready;
    out_word_t word;

    gearbox_in_stage u_in (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .clear      (clear),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_ready   (in_ready),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready)
    );

    gearbox_core u_core (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .clear      (clear),
        .out_bw     (out_bw),      // Core only
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready),
        .word_valid (word_valid),
        .word       (word),
        .word_ready (word_ready)
    );

    gearbox_out_stage u_out (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .clear      (clear),
        .word_valid (word_valid),
        .word       (word),
        .word_ready (word_ready),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// ==== logic/gearbox_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module gearbox_out_stage (
    input  wire                     CLK,
    input  wire                     RST_N,
    input  wire                     clear,
    input  wire                     word_valid,
    input  wire gearbox_pkg::out_word_t word,
    output logic                    word_ready,
    output logic                    out_valid,
    output gearbox_pkg::out_word_t  out_word,
    input  wire                     out_ready
);
    import gearbox_pkg::*;

    logic word_fire;

    // Load when empty or when the held word leaves this cycle
    assign word_ready = !out_valid || out_ready;
    assign word_fire  = word_valid && word_ready;

    // ==============================
    // Pipeline register
    // ==============================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            out_valid <= 1'b0;
        end else if (clear) begin
            out_valid <= 1'b0;
        end else if (word_ready) begin
            out_valid <= word_valid;   // Bubble if nothing offered
        end
    end

    always_ff @(posedge CLK) begin
        if (word_fire) begin
            out_word <= word;          // Payload only
        end
    end

    // Held word stays put under back-pressure
    a_out_hold : assert property (@(posedge CLK) disable iff (!RST_N || clear)
        out_valid && !out_ready |=> out_valid && $stable(out_word));

    // Every stored word came from a core word with bits
    a_out_nbits : assert property (@(posedge CLK) disable iff (!RST_N)
        out_valid |-> (out_word.nbits != '0) && (out_word.nbits <= OUT_W));

endmodule

`default_nettype wire

// ==== logic/gearbox_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module gearbox_core (
    input  wire                    CLK,
    input  wire                    RST_N,
    input  wire                    clear,
    input  wire gearbox_pkg::out_cnt_t out_bw,
    input  wire                    beat_valid,
    input  wire gearbox_pkg::in_beat_t beat,
    output logic                   beat_ready,
    output logic                   word_valid,
    output gearbox_pkg::out_word_t word,
    input  wire                    word_ready
);
    import gearbox_pkg::*;

    typedef logic [$bits(buf_cnt_t):0] sum_t; // Count plus one beat

    logic [BUF_W-1:0] acc;       // Bit accumulator, LSB oldest
    buf_cnt_t         cnt;       // Valid bits held
    acc_state_t       state;

    buf_cnt_t         bw;        // out_bw at count width
    buf_cnt_t         emit_cnt;  // min(cnt, out_bw)
    buf_cnt_t         cnt_left;  // Count after this cycle's emit
    sum_t             space_sum;
    logic             emit_fire;
    logic             beat_fire;
    logic [OUT_W-1:0] word_mask;
    logic [IN_W-1:0]  beat_mask;
    logic [BUF_W-1:0] acc_shift;
    logic [BUF_W-1:0] keep_mask;
    logic [BUF_W-1:0] acc_ins;
    logic [BUF_W-1:0] acc_d;
    buf_cnt_t         cnt_d;

    // ==============================
    // Emit side
    // ==============================
    assign bw         = buf_cnt_t'(out_bw);
    assign emit_cnt   = (cnt < bw) ? cnt : bw;
    assign word_valid = (cnt >= bw) || ((state == ACC_DRAIN) && (cnt != '0)); // Full or tail
    assign word_mask  = ~({OUT_W{1'b1}} << emit_cnt); // Ones below emit_cnt
    assign emit_fire  = word_valid && word_ready;

    always_comb begin
        word.data  = acc[OUT_W-1:0] & word_mask;       // Zeros above valid bits
        word.nbits = out_cnt_t'(emit_cnt);
        word.last  = (state == ACC_DRAIN) && (cnt <= bw); // Remainder fits
    end

    // ==============================
    // Insert side
    // ==============================
    assign cnt_left   = emit_fire ? cnt - emit_cnt : cnt;
    assign space_sum  = sum_t'(cnt_left) + sum_t'(beat.nbits);
    assign beat_ready = (state == ACC_FILL) && (space_sum <= sum_t'(BUF_W)); // Room after emit
    assign beat_fire  = beat_valid && beat_ready;

    // Shift out the emitted word, then place the beat above what remains
    assign acc_shift = emit_fire ? acc >> emit_cnt : acc;
    assign keep_mask = ~({BUF_W{1'b1}} << cnt_left);   // Stale bits dropped
    assign beat_mask = ~({IN_W{1'b1}} << beat.nbits);
    assign acc_ins   = BUF_W'(beat.data & beat_mask) << cnt_left;
    assign acc_d     = beat_fire ? ((acc_shift & keep_mask) | acc_ins) : acc_shift;
    assign cnt_d     = beat_fire ? buf_cnt_t'(space_sum) : cnt_left;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            cnt   <= '0;
            state <= ACC_FILL;
        end else if (clear) begin
            cnt   <= '0;
            state <= ACC_FILL;
        end else begin
            cnt <= cnt_d;
            if (emit_fire && word.last) begin
                state <= ACC_FILL;                      // Tail gone
            end else if (beat_fire && beat.last) begin
                state <= ACC_DRAIN;                     // Hold off next packet
            end
        end
    end

    always_ff @(posedge CLK) begin
        acc <= acc_d;                                   // Bits above cnt are don't-care
    end

    // ==============================
    // Checks
    // ==============================
    a_bw_range : assert property (@(posedge CLK) disable iff (!RST_N)
        (out_bw != '0) && (out_bw <= OUT_W));

    // Width only changes between packets
    a_bw_stable : assert property (@(posedge CLK) disable iff (!RST_N || clear)
        (cnt != '0) |-> $stable(out_bw));

    a_cnt_bound : assert property (@(posedge CLK) disable iff (!RST_N)
        cnt <= BUF_W);

endmodule

`default_nettype wire

// ==== logic/gearbox_in_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module gearbox_in_stage (
    input  wire                   CLK,
    input  wire                   RST_N,
    input  wire                   clear,
    input  wire                   in_valid,
    input  wire gearbox_pkg::in_beat_t in_beat,
    output logic                  in_ready,
    output logic                  beat_valid,
    output gearbox_pkg::in_beat_t beat,
    input  wire                   beat_ready
);
    import gearbox_pkg::*;

    logic     s_valid;   // Skid entry occupied
    in_beat_t s_beat;    // Skid payload
    logic     m_valid_d;
    in_beat_t m_beat_d;
    logic     s_valid_d;
    in_beat_t s_beat_d;
    logic     in_fire;
    logic     main_free;

    assign in_fire   = in_valid && in_ready;
    assign main_free = !beat_valid || beat_ready; // Main empties or hands off

    // ==============================
    // Next-state of both entries
    // ==============================
    always_comb begin
        m_valid_d = beat_valid;
        m_beat_d  = beat;
        s_valid_d = s_valid;
        s_beat_d  = s_beat;
        if (main_free) begin
            if (s_valid) begin           // Skid moves up first
                m_valid_d = 1'b1;
                m_beat_d  = s_beat;
                s_valid_d = 1'b0;
            end else begin
                m_valid_d = in_fire;     // Straight into main
                if (in_fire) begin
                    m_beat_d = in_beat;
                end
            end
        end else if (in_fire) begin      // Main stalled, park in skid
            s_valid_d = 1'b1;
            s_beat_d  = in_beat;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            beat_valid <= 1'b0;
            s_valid    <= 1'b0;
            in_ready   <= 1'b0;          // Rises on first edge out of reset
        end else if (clear) begin
            beat_valid <= 1'b0;
            s_valid    <= 1'b0;
            in_ready   <= 1'b1;
        end else begin
            beat_valid <= m_valid_d;
            s_valid    <= s_valid_d;
            in_ready   <= !s_valid_d;    // Registered, not from core
        end
    end

    always_ff @(posedge CLK) begin
        beat   <= m_beat_d;
        s_beat <= s_beat_d;
    end

    // Beat widths on the accepted input
    a_nbits_legal : assert property (@(posedge CLK) disable iff (!RST_N)
        in_fire |-> (in_beat.nbits != '0) && (in_beat.nbits <= IN_W));

    // Offered beat held until the core takes it
    a_beat_hold : assert property (@(posedge CLK) disable iff (!RST_N || clear)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

`default_nettype wire

// ==== logic/gearbox_pkg.sv ====
`default_nettype none

package gearbox_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int IN_W  = 16;           // Input beat data width
    localparam int OUT_W = 32;           // Widest output word
    localparam int BUF_W = IN_W + OUT_W; // Accumulator capacity

    typedef logic [$clog2(IN_W + 1)-1:0]  in_cnt_t;  // 0..IN_W
    typedef logic [$clog2(OUT_W + 1)-1:0] out_cnt_t; // 0..OUT_W, also out_bw
    typedef logic [$clog2(BUF_W + 1)-1:0] buf_cnt_t; // 0..BUF_W

    // ==============================
    // Stream payloads
    // ==============================
    typedef struct packed {
        logic [IN_W-1:0] data;  // LSB-first bits
        in_cnt_t         nbits; // Valid bits in data
        logic            last;  // Packet end
    } in_beat_t;

    typedef struct packed {
        logic [OUT_W-1:0] data;  // Zero above nbits
        out_cnt_t         nbits; // Bits carried
        logic             last;  // Tail word of packet
    } out_word_t;

    // Accumulator state
    typedef enum logic {
        ACC_FILL  = 1'b0, // Taking beats
        ACC_DRAIN = 1'b1  // Last beat in, flushing tail
    } acc_state_t;

endpackage

`default_nettype wire
